// File: logic/eth_log_defines.svh
// Frame log sizing constants shared by the packer, the FIFOs and the testbench
`ifndef ETH_LOG_DEFINES_SVH
`define ETH_LOG_DEFINES_SVH

// Scripts annotating each frame byte
`define NUM_SCRIPTS 4

// Log word width, 8 bytes per word
`define LOG_WIDTH 64

// Frame FIFO depth in log words
`define FRAME_FIFO_DEPTH 16

// Control FIFO depth in records
`define CTL_FIFO_DEPTH 4

// Control record: match mask, 16-bit size, 64-bit timestamp
`define CTL_WIDTH (`NUM_SCRIPTS + 80)

`endif

// File: logic/eth_frame_pkg.sv
// Types of the annotated Ethernet frame byte stream fed to the packer
`include "eth_log_defines.svh"

package eth_frame_pkg;

	// One frame byte
	typedef logic [7:0] byte_t;

	// One bit per script, used for both the matched and the extract flags
	typedef logic [`NUM_SCRIPTS-1:0] script_mask_t;

	// Free-running time base
	typedef logic [63:0] timestamp_t;

	// Count of extracted bytes in one frame
	typedef logic [15:0] frame_size_t;

endpackage

// File: logic/log_record_pkg.sv
// Types of the packed log words, the control records and the packer FSM
`include "eth_log_defines.svh"

package log_record_pkg;

	// One packed log word, first kept byte in the lowest lane
	typedef logic [`LOG_WIDTH-1:0] log_word_t;

	// {match mask, extracted size, timestamp}
	typedef logic [`CTL_WIDTH-1:0] ctl_record_t;

	// Packer FSM
	typedef enum logic [1:0] {
		wait_start,
		capture,
		write_ctl,
		overflow
	} packer_state_t;

endpackage

// File: logic/log_fifo.sv
// Synchronous first-word-fall-through FIFO with valid/ready on both sides
`timescale 1ns/1ps

module log_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic [WIDTH-1:0] in_data,
	input  logic             in_valid,
	output logic             in_ready,

	output logic [WIDTH-1:0] out_data,
	output logic             out_valid,
	input  logic             out_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];

	assign push = in_valid & in_ready;
	assign pop  = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end

			// Simultaneous push and pop leaves the occupancy unchanged
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/extract_packer.sv
// Extracts flagged frame bytes into log words and writes one control record per frame
`timescale 1ns/1ps

module extract_packer (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         srst,
	input  logic                         enable,
	input  eth_frame_pkg::timestamp_t    current_time,

	input  eth_frame_pkg::byte_t         in_data,
	input  logic                         in_valid,
	input  logic                         in_last,
	input  eth_frame_pkg::script_mask_t  in_matched,
	input  eth_frame_pkg::script_mask_t  in_extract,

	output log_record_pkg::log_word_t    word_data,
	output logic                         word_valid,
	input  logic                         word_ready,

	output log_record_pkg::ctl_record_t  rec_data,
	output logic                         rec_valid,
	input  logic                         rec_ready,

	output logic [63:0]                  overflow_count
);

	localparam int LOG_W = $bits(log_record_pkg::log_word_t);
	localparam int BYTES = LOG_W / 8;
	localparam int IDX_W = $clog2(BYTES);
	localparam int SR_W  = LOG_W - 8;

	log_record_pkg::packer_state_t state;
	logic                          in_frame;
	eth_frame_pkg::frame_size_t    count;
	eth_frame_pkg::script_mask_t   mask_acc;

	// Kept bytes enter at the top and move down, oldest byte lowest
	logic [SR_W-1:0]               byte_sr;

	logic                          keep;
	logic [IDX_W-1:0]              lane;
	logic                          capture_byte;
	logic                          word_due;
	logic                          push_ok;
	logic                          drop;
	logic                          frame_end;
	logic [IDX_W:0]                n_bytes;
	log_record_pkg::log_word_t     packed_src;
	eth_frame_pkg::script_mask_t   frame_mask;
	eth_frame_pkg::frame_size_t    size_kept;
	eth_frame_pkg::frame_size_t    drop_size;

	// Valid bytes sit in the top n lanes of src; move them to the bottom
	function automatic log_record_pkg::log_word_t align_low(
		input log_record_pkg::log_word_t src,
		input logic [IDX_W:0]            n
	);
		return src >> (8 * (BYTES - int'(n)));
	endfunction

	assign keep         = |(in_matched & in_extract);
	assign lane         = count[IDX_W-1:0];
	assign capture_byte = (state == log_record_pkg::capture) & in_valid;

	// A word leaves on its last lane, or at frame end when a partial word is held
	assign word_due = capture_byte &
		(keep ? ((lane == '1) | in_last) : (in_last & (lane != '0)));
	assign push_ok  = word_due & word_ready;
	assign drop     = word_due & ~word_ready;

	assign frame_end = capture_byte & in_last & ~drop;

	assign n_bytes    = keep ? ({1'b0, lane} + 1'b1) : {1'b0, lane};
	assign packed_src = keep ? {in_data, byte_sr} : {byte_sr, 8'd0};
	assign frame_mask = mask_acc | in_matched;
	assign size_kept  = count + eth_frame_pkg::frame_size_t'(keep);

	// Size up to the drop covers only bytes that reach the frame FIFO
	assign drop_size = word_valid ? (count - eth_frame_pkg::frame_size_t'(lane)) : size_kept;

	// Payload registers
	always_ff @(posedge clk) begin
		if (capture_byte & keep & ~word_due) begin
			byte_sr <= {in_data, byte_sr[SR_W-1:8]};
		end

		// A word still waiting in the output register is never overwritten
		if (push_ok | (drop & ~word_valid)) begin
			word_data <= align_low(packed_src, n_bytes);
		end

		if (frame_end) begin
			rec_data <= {frame_mask, size_kept, current_time};
		end else if (drop) begin
			rec_data <= {eth_frame_pkg::script_mask_t'(0), drop_size, current_time};
		end
	end

	// Packer FSM and push handshakes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= log_record_pkg::wait_start;
			in_frame   <= 1'b0;
			count      <= '0;
			mask_acc   <= '0;
			word_valid <= 1'b0;
			rec_valid  <= 1'b0;
		end else begin
			if (word_valid & word_ready) begin
				word_valid <= 1'b0;
			end
			if (rec_valid & rec_ready) begin
				rec_valid <= 1'b0;
			end

			if (in_valid) begin
				in_frame <= ~in_last;
			end

			case (state)
				log_record_pkg::wait_start: begin
					count    <= '0;
					mask_acc <= '0;
					// Arm only between frames, with room in both FIFOs
					if (enable & ~in_frame & ~in_valid & word_ready & rec_ready) begin
						state <= log_record_pkg::capture;
					end
				end

				log_record_pkg::capture: begin
					if (in_valid) begin
						mask_acc <= frame_mask;
						if (keep) begin
							count <= count + 1'b1;
						end

						if (push_ok | drop) begin
							word_valid <= 1'b1;
						end

						if (drop) begin
							state <= log_record_pkg::overflow;
						end else if (in_last) begin
							rec_valid <= 1'b1;
							state     <= log_record_pkg::write_ctl;
						end
					end else if (~in_frame & ~enable) begin
						state <= log_record_pkg::wait_start;
					end
				end

				log_record_pkg::write_ctl: begin
					if (rec_valid & rec_ready) begin
						state <= log_record_pkg::wait_start;
					end
				end

				log_record_pkg::overflow: begin
					// Record follows once the held word has gone out
					if (~word_valid | word_ready) begin
						rec_valid <= 1'b1;
						state     <= log_record_pkg::write_ctl;
					end
				end

				default: begin
					state <= log_record_pkg::wait_start;
				end
			endcase
		end
	end

	// Dropped frames are counted at their last byte
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			overflow_count <= '0;
		end else if (srst) begin
			overflow_count <= '0;
		end else if (in_valid & in_last & ((state != log_record_pkg::capture) | drop)) begin
			overflow_count <= overflow_count + 64'd1;
		end
	end

endmodule

// File: logic/frame_log_top.sv
// Frame log top level, packer feeding the frame word FIFO and the control record FIFO
`timescale 1ns/1ps
`include "eth_log_defines.svh"

module frame_log_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         srst,
	input  logic                         enable,
	input  eth_frame_pkg::timestamp_t    current_time,

	input  eth_frame_pkg::byte_t         in_data,
	input  logic                         in_valid,
	input  logic                         in_last,
	input  eth_frame_pkg::script_mask_t  in_matched,
	input  eth_frame_pkg::script_mask_t  in_extract,

	output log_record_pkg::log_word_t    frame_data,
	output logic                         frame_valid,
	input  logic                         frame_ready,

	output log_record_pkg::ctl_record_t  ctl_data,
	output logic                         ctl_valid,
	input  logic                         ctl_ready,

	output logic [63:0]                  overflow_count
);

	log_record_pkg::log_word_t   word_data;
	logic                        word_valid;
	logic                        word_ready;

	log_record_pkg::ctl_record_t rec_data;
	logic                        rec_valid;
	logic                        rec_ready;

	extract_packer packer (
		.clk            (clk),
		.rst_n          (rst_n),
		.srst           (srst),
		.enable         (enable),
		.current_time   (current_time),
		.in_data        (in_data),
		.in_valid       (in_valid),
		.in_last        (in_last),
		.in_matched     (in_matched),
		.in_extract     (in_extract),
		.word_data      (word_data),
		.word_valid     (word_valid),
		.word_ready     (word_ready),
		.rec_data       (rec_data),
		.rec_valid      (rec_valid),
		.rec_ready      (rec_ready),
		.overflow_count (overflow_count)
	);

	log_fifo #(
		.WIDTH (`LOG_WIDTH),
		.DEPTH (`FRAME_FIFO_DEPTH)
	) frame_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (word_data),
		.in_valid  (word_valid),
		.in_ready  (word_ready),
		.out_data  (frame_data),
		.out_valid (frame_valid),
		.out_ready (frame_ready)
	);

	log_fifo #(
		.WIDTH (`CTL_WIDTH),
		.DEPTH (`CTL_FIFO_DEPTH)
	) ctl_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (rec_data),
		.in_valid  (rec_valid),
		.in_ready  (rec_ready),
		.out_data  (ctl_data),
		.out_valid (ctl_valid),
		.out_ready (ctl_ready)
	);

endmodule

// File: test/frame_log_checker.sv
// Protocol checker for the frame log outputs and the overflow counter
`timescale 1ns/1ps

module frame_log_checker (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        srst,
	input log_record_pkg::log_word_t   frame_data,
	input logic                        frame_valid,
	input logic                        frame_ready,
	input log_record_pkg::ctl_record_t ctl_data,
	input logic                        ctl_valid,
	input logic                        ctl_ready,
	input logic [63:0]                 overflow_count
);

	// Raised by any failing assertion below
	logic failed = 1'b0;

	// Offered word stays put until the reader takes it
	frame_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		frame_valid && !frame_ready |=> frame_valid && $stable(frame_data)
	) else begin
		$error("frame_valid fell or frame_data changed before frame_ready");
		failed = 1'b1;
	end

	ctl_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		ctl_valid && !ctl_ready |=> ctl_valid && $stable(ctl_data)
	) else begin
		$error("ctl_valid fell or ctl_data changed before ctl_ready");
		failed = 1'b1;
	end

	// Both FIFOs empty once reset is applied
	reset_idle: assert property (
		@(posedge clk)
		!rst_n |=> !frame_valid && !ctl_valid
	) else begin
		$error("frame_valid or ctl_valid high after reset");
		failed = 1'b1;
	end

	srst_clears: assert property (
		@(posedge clk) disable iff (!rst_n)
		srst |=> overflow_count == 64'd0
	) else begin
		$error("overflow_count not zero after srst");
		failed = 1'b1;
	end

	// Drop counter only moves up
	count_rises: assert property (
		@(posedge clk) disable iff (!rst_n)
		!srst |=> overflow_count >= $past(overflow_count)
	) else begin
		$error("overflow_count decreased without srst");
		failed = 1'b1;
	end

endmodule

// File: test/frame_log_tb.sv
// Frame log testbench checking random annotated frames against a packing model
`timescale 1ns/1ps
`include "eth_log_defines.svh"

module frame_log_tb;

	localparam int TIMEOUT  = 4000;
	localparam int NO_LIMIT = 1000;

	logic                        clk = 1'b0;
	logic                        rst_n;
	logic                        srst;
	logic                        enable;
	eth_frame_pkg::timestamp_t   current_time;
	eth_frame_pkg::byte_t        in_data;
	logic                        in_valid;
	logic                        in_last;
	eth_frame_pkg::script_mask_t in_matched;
	eth_frame_pkg::script_mask_t in_extract;
	log_record_pkg::log_word_t   frame_data;
	logic                        frame_valid;
	logic                        frame_ready;
	log_record_pkg::ctl_record_t ctl_data;
	logic                        ctl_valid;
	logic                        ctl_ready;
	logic [63:0]                 overflow_count;

	integer                      seed;
	logic [63:0]                 overflow_model;
	log_record_pkg::log_word_t   exp_words [$];
	log_record_pkg::ctl_record_t exp_recs [$];
	log_record_pkg::log_word_t   exp_word;
	log_record_pkg::ctl_record_t exp_rec;

	frame_log_top UUT (.*);

	bind frame_log_top frame_log_checker protocol_checks (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		current_time <= current_time + 64'd1;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Bound checker flags a failed protocol assertion
	always @(posedge UUT.protocol_checks.failed) begin
		report_failure("A protocol assertion in the bound checker failed");
	end

	always @(posedge clk) begin
		if (rst_n && frame_valid && frame_ready) begin
			if (exp_words.size() == 0) begin
				report_failure($sformatf("Frame word %h arrived at %0t with none expected",
					frame_data, $time));
			end else begin
				exp_word = exp_words.pop_front();
				assert (frame_data == exp_word)
				else report_failure($sformatf("Mismatch at %0t: frame_data got %h, expected %h",
					$time, frame_data, exp_word));
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n && ctl_valid && ctl_ready) begin
			if (exp_recs.size() == 0) begin
				report_failure($sformatf("Control record %h arrived at %0t with none expected",
					ctl_data, $time));
			end else begin
				exp_rec = exp_recs.pop_front();
				assert (ctl_data == exp_rec)
				else report_failure($sformatf("Mismatch at %0t: ctl_data got %h, expected %h",
					$time, ctl_data, exp_rec));
			end
		end
	end

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			in_valid <= 1'b0;
			in_last  <= 1'b0;
		end
	endtask

	// Drives one frame and queues what the packing rules predict for it
	task automatic send_frame(input int len, input bit all_kept, input bit armed, input int room);
		eth_frame_pkg::byte_t        b;
		eth_frame_pkg::script_mask_t m;
		eth_frame_pkg::script_mask_t x;
		eth_frame_pkg::script_mask_t mask;
		eth_frame_pkg::timestamp_t   ts;
		log_record_pkg::log_word_t   word;
		int                          kept;
		int                          words;
		bit                          dropped;
		bit                          last;
		mask    = '0;
		word    = '0;
		kept    = 0;
		words   = 0;
		dropped = 1'b0;
		for (int i = 0; i < len; i++) begin
			b    = $random(seed);
			m    = all_kept ? '1 : $random(seed);
			x    = all_kept ? '1 : $random(seed);
			last = (i == len - 1);
			@(posedge clk);
			in_data    <= b;
			in_valid   <= 1'b1;
			in_last    <= last;
			in_matched <= m;
			in_extract <= x;
			// Time value sampled together with this byte
			ts = current_time + 64'd1;
			if (armed && !dropped) begin
				mask = mask | m;
				if (|(m & x)) begin
					word[8 * (kept % 8) +: 8] = b;
					kept++;
				end
				if ((|(m & x) && kept % 8 == 0) || (last && kept % 8 != 0)) begin
					exp_words.push_back(word);
					word = '0;
					// Frame FIFO full but the held word still goes out
					if (words == room) begin
						dropped = 1'b1;
						exp_recs.push_back({eth_frame_pkg::script_mask_t'(0),
							eth_frame_pkg::frame_size_t'(kept), ts});
					end
					words++;
				end
				if (last && !dropped) begin
					exp_recs.push_back({mask, eth_frame_pkg::frame_size_t'(kept), ts});
				end
			end
		end
		if (!armed || dropped) begin
			overflow_model = overflow_model + 64'd1;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((exp_words.size() != 0 || exp_recs.size() != 0) && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_words.size() != 0 || exp_recs.size() != 0) begin
			report_failure("Timed out waiting for the expected words and records to arrive");
		end
	endtask

	// Last byte sits in cycle 0; the edge ending cycle n shows cycle n
	task automatic check_ctl_latency();
		int cycles;
		bit seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < 20) begin
			@(posedge clk);
			in_valid <= 1'b0;
			in_last  <= 1'b0;
			cycles++;
			seen = ctl_valid;
		end
		if (!seen) begin
			report_failure("Timed out waiting for ctl_valid after the last byte of a frame");
		end
		assert (cycles - 1 == 2)
		else report_failure($sformatf("Mismatch at %0t: ctl_valid latency got %0d, expected 2",
			$time, cycles - 1));
	endtask

	task automatic check_overflow();
		@(negedge clk);
		assert (overflow_count == overflow_model)
		else report_failure($sformatf("Mismatch at %0t: overflow_count got %0d, expected %0d",
			$time, overflow_count, overflow_model));
	endtask

	task automatic clear_overflow();
		@(posedge clk);
		srst <= 1'b1;
		@(posedge clk);
		srst <= 1'b0;
		overflow_model = '0;
		check_overflow();
	endtask

	initial begin
		int len;
		seed           = 32'h2da2e5c8;
		overflow_model = '0;
		current_time   = 64'h0000_0042_0000_0000;
		rst_n          = 1'b0;
		srst           = 1'b0;
		enable         = 1'b0;
		in_data        = '0;
		in_valid       = 1'b0;
		in_last        = 1'b0;
		in_matched     = '0;
		in_extract     = '0;
		frame_ready    = 1'b1;
		ctl_ready      = 1'b1;

		repeat (3) @(posedge clk);
		rst_n  <= 1'b1;
		enable <= 1'b1;
		idle(4);

		// Every byte kept
		repeat (4) begin
			len = {$random(seed)} % 40 + 1;
			send_frame(len, 1'b1, 1'b1, NO_LIMIT);
			idle(4);
		end
		wait_drain();

		// Random flags with some bytes skipped
		repeat (6) begin
			len = {$random(seed)} % 40 + 1;
			send_frame(len, 1'b0, 1'b1, NO_LIMIT);
			idle(4);
		end
		wait_drain();

		// Reader holds off the control FIFO for three records
		idle(4);
		ctl_ready <= 1'b0;
		repeat (3) begin
			len = {$random(seed)} % 40 + 1;
			send_frame(len, 1'b0, 1'b1, NO_LIMIT);
			idle(4);
		end
		ctl_ready <= 1'b1;
		wait_drain();

		idle(4);
		send_frame(6, 1'b0, 1'b1, NO_LIMIT);
		check_ctl_latency();
		wait_drain();

		// Reader stalls the frame FIFO during a long frame
		idle(4);
		frame_ready <= 1'b0;
		send_frame(160, 1'b1, 1'b1, `FRAME_FIFO_DEPTH);
		idle(10);
		frame_ready <= 1'b1;
		wait_drain();
		check_overflow();

		// Second frame starts while the first record is still going out
		idle(4);
		send_frame(12, 1'b0, 1'b1, NO_LIMIT);
		send_frame(8, 1'b0, 1'b0, NO_LIMIT);
		idle(4);
		enable <= 1'b0;
		idle(4);
		send_frame(10, 1'b0, 1'b0, NO_LIMIT);
		idle(4);
		enable <= 1'b1;
		wait_drain();
		check_overflow();

		clear_overflow();
		idle(4);
		enable <= 1'b0;
		idle(4);
		send_frame(7, 1'b0, 1'b0, NO_LIMIT);
		idle(4);
		enable <= 1'b1;
		idle(4);
		send_frame(9, 1'b1, 1'b1, NO_LIMIT);
		idle(4);
		wait_drain();
		idle(20);

		@(negedge clk);
		assert (overflow_count == overflow_model) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			report_failure($sformatf("Mismatch at %0t: overflow_count got %0d, expected %0d",
				$time, overflow_count, overflow_model));
		end
	end

endmodule

// File: sources.f
+incdir+logic
logic/eth_frame_pkg.sv
logic/log_record_pkg.sv
logic/log_fifo.sv
logic/extract_packer.sv
logic/frame_log_top.sv
test/frame_log_checker.sv
test/frame_log_tb.sv
